/* alu_lane.f */
hw/alu_pkg.sv
hw/alu_op_if.sv
hw/operand_bypass.sv
hw/op_decode.sv
hw/add_logic_unit.sv
hw/shift_unit.sv
hw/result_merge.sv
hw/alu_lane.sv
testbench/alu_lane_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits nonzero unless the run passes.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f alu_lane.f --top-module alu_lane_tb \
  -Mdir obj_dir -o alu_lane_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

output=$(./obj_dir/alu_lane_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
exit 1

/* testbench/alu_lane_tb.sv */
// Runs the lane at 64 bits with known opcodes only and a model that retires each issue 3 cycles later.
`timescale 1ns/1ps
`default_nettype none

module alu_lane_tb;
  import alu_pkg::*;

  localparam int DATA_W       = DEFAULT_DATA_W;
  localparam int RESET_CYCLES = 8;
  localparam int STIM_CYCLES  = 1500;
  localparam int MAX_CYCLES   = 2000;  // stimulus, reset and drain with room to spare.
  localparam int ENTRY_W      = 1 + OPC_W + 2 * DATA_W;

  logic              clk;
  logic              reset;
  logic              issue_valid;
  logic [OPC_W-1:0]  issue_op;
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic              a_fwd;
  logic              b_fwd;
  logic              result_valid;
  logic [DATA_W-1:0] result;
  logic [FLAG_W-1:0] flags;

  logic [ENTRY_W-1:0] pipe[$];  // one entry per cycle with the valid bit on top.
  logic [DATA_W-1:0]  ref_result;
  logic               exp_valid;
  logic [DATA_W-1:0]  exp_result;
  logic [FLAG_W-1:0]  exp_flags;
  int                 in_flight = 0;
  int                 results_checked = 0;
  int                 errors = 0;
  int                 cycle_count = 0;

  alu_lane #(.DATA_W(DATA_W)) UUT (
    .clk          (clk),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .a            (a),
    .b            (b),
    .a_fwd        (a_fwd),
    .b_fwd        (b_fwd),
    .result_valid (result_valid),
    .result       (result),
    .flags        (flags)
  );

  always #4 clk = ~clk;  // 8 ns period.

  // ###################################################################
  // reference model
  // ###################################################################
  function automatic void reference_op(
    input  logic [OPC_W-1:0]  op,
    input  logic [DATA_W-1:0] x,
    input  logic [DATA_W-1:0] y,
    output logic [DATA_W-1:0] res,
    output logic [FLAG_W-1:0] fl,
    output logic              writes
  );
    logic [OPC_W-1:0]  base;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] top;
    logic [DATA_W-1:0] xa;
    logic [DATA_W-1:0] yb;
    logic [DATA_W-1:0] amt;
    int                w;
    logic              c;
    logic              v;
    base               = op;
    base[OPC_HALF_BIT] = 1'b0;
    w      = op[OPC_HALF_BIT] ? DATA_W / 2 : DATA_W;
    mask   = {DATA_W{1'b1}} >> (DATA_W - w);
    top    = mask & ~(mask >> 1);  // sign bit of the active width.
    xa     = x & mask;
    yb     = y & mask;
    amt    = y & DATA_W'(w - 1);
    c      = 1'b0;
    v      = 1'b0;
    writes = 1'b1;
    case (base)
      OPC_ADD: begin
        res = (xa + yb) & mask;
        c   = res < xa;  // the sum wrapped past the top of the width.
        v   = ((xa ^ res) & (yb ^ res) & top) != '0;
      end
      OPC_SUB, OPC_CMP: begin
        res    = (xa - yb) & mask;
        c      = xa >= yb;  // set when there is no borrow.
        v      = ((xa ^ yb) & (xa ^ res) & top) != '0;
        writes = base == OPC_SUB;
      end
      OPC_AND: res = xa & yb;
      OPC_OR:  res = xa | yb;
      OPC_XOR: res = xa ^ yb;
      OPC_SHL: res = (xa << amt) & mask;
      OPC_SHR: res = xa >> amt;
      OPC_SAR: begin
        res = xa >> amt;
        if ((xa & top) != '0) begin
          res = (res | ~(mask >> amt)) & mask;
        end
      end
      default: res = '0;
    endcase
    fl             = '0;
    fl[FLAG_ZERO]  = res == '0;
    fl[FLAG_SIGN]  = (res & top) != '0;
    fl[FLAG_CARRY] = c;
    fl[FLAG_OVF]   = v;
  endfunction

  always @(posedge clk) begin : model
    logic [ENTRY_W-1:0] old;
    logic [DATA_W-1:0]  res;
    logic [FLAG_W-1:0]  fl;
    logic               writes;
    int                 pending;
    if (reset) begin
      pipe.delete();
      ref_result = '0;
      exp_valid  <= 1'b0;
      exp_result <= '0;
      exp_flags  <= '0;
      in_flight  <= 0;
    end else begin
      exp_valid <= 1'b0;
      // operands see the result port as it stands before this edge.
      pipe.push_back({issue_valid, issue_op, a_fwd ? ref_result : a, b_fwd ? ref_result : b});
      if (pipe.size() > 2) begin
        old = pipe.pop_front();
        if (old[ENTRY_W-1]) begin
          reference_op(old[2*DATA_W +: OPC_W], old[DATA_W +: DATA_W], old[0 +: DATA_W],
                       res, fl, writes);
          if (writes) begin
            ref_result = res;
          end
          exp_valid  <= 1'b1;
          exp_result <= ref_result;
          exp_flags  <= fl;
          results_checked++;
        end
      end
      pending = 0;
      foreach (pipe[i]) begin
        if (pipe[i][ENTRY_W-1]) begin
          pending++;
        end
      end
      in_flight <= pending;
    end
  end

  // ###################################################################
  // checks
  // ###################################################################
  chk_valid: assert property (@(posedge clk) disable iff (reset) result_valid == exp_valid)
    else begin
      errors++;
      $display("Mismatch at %0t: result_valid %0b, expected %0b", $time,
               $sampled(result_valid), $sampled(exp_valid));
    end

  chk_result: assert property (@(posedge clk) disable iff (reset) result == exp_result)
    else begin
      errors++;
      $display("Mismatch at %0t: result %h, expected %h", $time,
               $sampled(result), $sampled(exp_result));
    end

  chk_flags: assert property (@(posedge clk) disable iff (reset) flags == exp_flags)
    else begin
      errors++;
      $display("Mismatch at %0t: flags %b, expected %b", $time,
               $sampled(flags), $sampled(exp_flags));
    end

  // ###################################################################
  // stimulus
  // ###################################################################
  function automatic logic [DATA_W-1:0] pick_operand();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    case ($urandom() % 8)
      0: return '0;
      1: return '1;
      2: return {1'b1, {(DATA_W-1){1'b0}}};
      3: return {1'b0, {(DATA_W-1){1'b1}}};
      4: return DATA_W'(1) << (DATA_W / 2 - 1);  // sign bit of the half width.
      5: return DATA_W'($urandom() % 8);
      default: return raw[DATA_W-1:0];
    endcase
  endfunction

  function automatic logic [OPC_W-1:0] pick_opcode();
    logic [OPC_W-1:0] op;
    case ($urandom() % 9)
      0: op = OPC_ADD;
      1: op = OPC_SUB;
      2: op = OPC_AND;
      3: op = OPC_OR;
      4: op = OPC_XOR;
      5: op = OPC_CMP;
      6: op = OPC_SHL;
      7: op = OPC_SHR;
      default: op = OPC_SAR;
    endcase
    op[OPC_HALF_BIT] = ($urandom() % 2) == 1;
    return op;
  endfunction

  task automatic drive_issue(input int step);
    issue_valid <= (step < 1000) || (($urandom() % 4) != 0);  // gaps only in the last third.
    issue_op    <= pick_opcode();
    a           <= pick_operand();
    b           <= pick_operand();
    a_fwd       <= ($urandom() % (step < 500 ? 4 : 2)) == 0;
    b_fwd       <= ($urandom() % (step < 500 ? 4 : 2)) == 0;
  endtask

  task automatic end_run(input bit timed_out);
    $display("Results checked: %0d, errors: %0d, timeouts: %0d", results_checked, errors,
             timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  initial begin : stimulus
    int step;
    void'($urandom(32'h4fae));
    clk         = 1'b0;
    reset       = 1'b1;
    issue_valid = 1'b0;
    issue_op    = '0;
    a           = '0;
    b           = '0;
    a_fwd       = 1'b0;
    b_fwd       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    for (step = 0; step < STIM_CYCLES; step++) begin
      @(posedge clk);
      drive_issue(step);
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    @(posedge clk);
    while (in_flight != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);  // the last retired result is sampled here.
    end_run(1'b0);
  end

  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
    end_run(1'b1);
  end

endmodule

`default_nettype wire

/* hw/alu_lane.sv */
// Fixed three-cycle latency with no stall, so every result must be taken in the cycle it appears.
`timescale 1ns/1ps
`default_nettype none

module alu_lane #(
  parameter int DATA_W = alu_pkg::DEFAULT_DATA_W
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       issue_valid,
  input  logic [alu_pkg::OPC_W-1:0]  issue_op,
  input  logic [DATA_W-1:0]          a,
  input  logic [DATA_W-1:0]          b,
  input  logic                       a_fwd,
  input  logic                       b_fwd,
  output logic                       result_valid,
  output logic [DATA_W-1:0]          result,
  output logic [alu_pkg::FLAG_W-1:0] flags
);

  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] sum;
  logic              carry;
  logic              ovf;
  logic [DATA_W-1:0] shifted;

  alu_op_if ctl_if ();

  // ###################################################################
  // stage 1
  // ###################################################################
  op_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .ctl         (ctl_if)
  );

  operand_bypass #(.DATA_W(DATA_W)) u_bypass (
    .clk         (clk),
    .reset       (reset),
    .a           (a),
    .b           (b),
    .a_fwd       (a_fwd),
    .b_fwd       (b_fwd),
    .last_result (result),
    .op_a        (op_a),
    .op_b        (op_b)
  );

  // ###################################################################
  // stages 2 and 3
  // ###################################################################
  add_logic_unit #(.DATA_W(DATA_W)) u_add (
    .clk   (clk),
    .reset (reset),
    .op_a  (op_a),
    .op_b  (op_b),
    .ctl   (ctl_if),
    .sum   (sum),
    .carry (carry),
    .ovf   (ovf)
  );

  shift_unit #(.DATA_W(DATA_W)) u_shift (
    .clk     (clk),
    .reset   (reset),
    .op_a    (op_a),
    .op_b    (op_b),
    .ctl     (ctl_if),
    .shifted (shifted)
  );

  result_merge #(.DATA_W(DATA_W)) u_merge (
    .clk          (clk),
    .reset        (reset),
    .sum          (sum),
    .carry        (carry),
    .ovf          (ovf),
    .shifted      (shifted),
    .ctl          (ctl_if),
    .result_valid (result_valid),
    .result       (result),
    .flags        (flags)
  );

endmodule

`default_nettype wire

/* hw/result_merge.sv */
// The result register also feeds the bypass, so it changes only on operations that write it.
`timescale 1ns/1ps
`default_nettype none

module result_merge #(
  parameter int DATA_W = 64
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [DATA_W-1:0]          sum,
  input  logic                       carry,
  input  logic                       ovf,
  input  logic [DATA_W-1:0]          shifted,
  alu_op_if.unit                     ctl,
  output logic                       result_valid,
  output logic [DATA_W-1:0]          result,
  output logic [alu_pkg::FLAG_W-1:0] flags
);
  import alu_pkg::*;

  localparam int HALF_W = DATA_W / 2;

  logic              valid_q;
  logic              is_shift_q;
  logic              half_q;
  logic              write_q;
  logic [DATA_W-1:0] sel;
  logic [FLAG_W-1:0] flags_d;

  always_comb begin
    sel     = is_shift_q ? shifted : sum;
    flags_d = '0;
    flags_d[FLAG_ZERO]  = half_q ? (sel[HALF_W-1:0] == '0) : (sel == '0);
    flags_d[FLAG_SIGN]  = half_q ? sel[HALF_W-1] : sel[DATA_W-1];
    flags_d[FLAG_CARRY] = carry & ~is_shift_q;
    flags_d[FLAG_OVF]   = ovf & ~is_shift_q;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q      <= 1'b0;
      is_shift_q   <= 1'b0;
      half_q       <= 1'b0;
      write_q      <= 1'b0;
      result_valid <= 1'b0;
      result       <= '0;
      flags        <= '0;
    end else begin
      valid_q      <= ctl.valid;  // control now lines up with the unit registers.
      is_shift_q   <= ctl.is_shift;
      half_q       <= ctl.half;
      write_q      <= ctl.write_result;
      result_valid <= valid_q;
      if (valid_q) begin
        flags <= flags_d;
      end
      if (valid_q && write_q) begin
        result <= sel;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/shift_unit.sv */
// Shift count is the low log2(DATA_W) bits of b, one bit fewer at half width, and larger counts wrap.
`timescale 1ns/1ps
`default_nettype none

module shift_unit #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] op_a,
  input  logic [DATA_W-1:0] op_b,
  alu_op_if.unit            ctl,
  output logic [DATA_W-1:0] shifted
);

  localparam int HALF_W = DATA_W / 2;
  localparam int SH_W   = $clog2(DATA_W);

  logic [SH_W-1:0]     amt;
  logic                fill;
  logic [DATA_W-1:0]   src;
  logic [2*DATA_W-1:0] right_wide;
  logic [DATA_W-1:0]   raw;

  always_comb begin
    if (ctl.half) begin
      amt  = {1'b0, op_b[SH_W-2:0]};
      fill = ctl.shift_arith & op_a[HALF_W-1];
      src  = {{HALF_W{fill}}, op_a[HALF_W-1:0]};  // sign sits above the half already.
    end else begin
      amt  = op_b[SH_W-1:0];
      fill = ctl.shift_arith & op_a[DATA_W-1];
      src  = op_a;
    end
    // one right shifter serves shr and sar through the fill word.
    right_wide = {{DATA_W{fill}}, src} >> amt;
    raw        = ctl.shift_dir ? right_wide[DATA_W-1:0] : src << amt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      shifted <= '0;
    end else if (ctl.valid && ctl.is_shift) begin
      shifted <= ctl.half ? {{HALF_W{1'b0}}, raw[HALF_W-1:0]} : raw;
    end
  end

endmodule

`default_nettype wire

/* hw/add_logic_unit.sv */
// Carry and overflow are taken at the active width and read as zero for the bitwise functions.
`timescale 1ns/1ps
`default_nettype none

module add_logic_unit #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] op_a,
  input  logic [DATA_W-1:0] op_b,
  alu_op_if.unit            ctl,
  output logic [DATA_W-1:0] sum,
  output logic              carry,
  output logic              ovf
);
  import alu_pkg::*;

  localparam int HALF_W = DATA_W / 2;

  logic [DATA_W-1:0] b_eff;
  logic [DATA_W:0]   full_sum;
  logic [HALF_W:0]   half_sum;
  logic              full_ovf;
  logic              half_ovf;
  logic [DATA_W-1:0] value;
  logic              carry_d;
  logic              ovf_d;

  // ###################################################################
  // the adder subtracts by adding the inverted b plus one
  // ###################################################################
  assign b_eff    = ctl.is_sub ? ~op_b : op_b;
  assign full_sum = {1'b0, op_a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, ctl.is_sub};
  assign half_sum = {1'b0, op_a[HALF_W-1:0]} + {1'b0, b_eff[HALF_W-1:0]}
                  + {{HALF_W{1'b0}}, ctl.is_sub};

  // signed overflow when both inputs agree in sign and the sum does not.
  assign full_ovf = (op_a[DATA_W-1] == b_eff[DATA_W-1]) &&
                    (full_sum[DATA_W-1] != op_a[DATA_W-1]);
  assign half_ovf = (op_a[HALF_W-1] == b_eff[HALF_W-1]) &&
                    (half_sum[HALF_W-1] != op_a[HALF_W-1]);

  always_comb begin
    carry_d = 1'b0;
    ovf_d   = 1'b0;
    case (ctl.logic_fn)
      LFN_AND: value = op_a & op_b;
      LFN_OR:  value = op_a | op_b;
      LFN_XOR: value = op_a ^ op_b;
      default: begin
        value   = full_sum[DATA_W-1:0];  // low half matches half_sum.
        carry_d = ctl.half ? half_sum[HALF_W] : full_sum[DATA_W];
        ovf_d   = ctl.half ? half_ovf : full_ovf;
      end
    endcase
    if (ctl.half) begin
      value = {{HALF_W{1'b0}}, value[HALF_W-1:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum   <= '0;
      carry <= 1'b0;
      ovf   <= 1'b0;
    end else if (ctl.valid && !ctl.is_shift) begin
      sum   <= value;  // idle when the shifter owns the slot.
      carry <= carry_d;
      ovf   <= ovf_d;
    end
  end

endmodule

`default_nettype wire

/* hw/op_decode.sv */
// Opcodes outside the map decode as an add that updates the flags and leaves the result alone.
`timescale 1ns/1ps
`default_nettype none

module op_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      issue_valid,
  input  logic [alu_pkg::OPC_W-1:0] issue_op,
  alu_op_if.decode                  ctl
);
  import alu_pkg::*;

  logic [OPC_W-1:0] base_op;
  logic             is_shift_d;
  logic             is_sub_d;
  logic [1:0]       logic_fn_d;
  logic             arith_d;
  logic             dir_d;
  logic             write_d;

  always_comb begin
    base_op               = issue_op;
    base_op[OPC_HALF_BIT] = 1'b0;  // width is handled apart from the base code.
    is_shift_d = 1'b0;
    is_sub_d   = 1'b0;
    logic_fn_d = LFN_NONE;
    arith_d    = 1'b0;
    dir_d      = 1'b0;
    write_d    = 1'b1;
    case (base_op)
      OPC_ADD: ;
      OPC_SUB: is_sub_d = 1'b1;
      OPC_AND: logic_fn_d = LFN_AND;
      OPC_OR:  logic_fn_d = LFN_OR;
      OPC_XOR: logic_fn_d = LFN_XOR;
      OPC_CMP: begin
        is_sub_d = 1'b1;
        write_d  = 1'b0;
      end
      OPC_SHL: is_shift_d = 1'b1;
      OPC_SHR: begin
        is_shift_d = 1'b1;
        dir_d      = 1'b1;
      end
      OPC_SAR: begin
        is_shift_d = 1'b1;
        dir_d      = 1'b1;
        arith_d    = 1'b1;
      end
      default: write_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctl.valid        <= 1'b0;
      ctl.is_shift     <= 1'b0;
      ctl.is_sub       <= 1'b0;
      ctl.logic_fn     <= LFN_NONE;
      ctl.half         <= 1'b0;
      ctl.shift_arith  <= 1'b0;
      ctl.shift_dir    <= 1'b0;
      ctl.write_result <= 1'b0;
    end else begin
      ctl.valid        <= issue_valid;
      ctl.is_shift     <= is_shift_d;
      ctl.is_sub       <= is_sub_d;
      ctl.logic_fn     <= logic_fn_d;
      ctl.half         <= issue_op[OPC_HALF_BIT];
      ctl.shift_arith  <= arith_d;
      ctl.shift_dir    <= dir_d;
      ctl.write_result <= write_d;
    end
  end

endmodule

`default_nettype wire

/* hw/operand_bypass.sv */
// The only bypass source is this lane's own result port, sampled in the issue cycle.
`timescale 1ns/1ps
`default_nettype none

module operand_bypass #(
  parameter int DATA_W = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic              a_fwd,
  input  logic              b_fwd,
  input  logic [DATA_W-1:0] last_result,
  output logic [DATA_W-1:0] op_a,
  output logic [DATA_W-1:0] op_b
);

  logic [DATA_W-1:0] a_sel;
  logic [DATA_W-1:0] b_sel;

  // each operand picks its own source.
  assign a_sel = a_fwd ? last_result : a;
  assign b_sel = b_fwd ? last_result : b;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_a <= '0;
      op_b <= '0;
    end else begin
      op_a <= a_sel;  // stage 1 operand register.
      op_b <= b_sel;
    end
  end

endmodule

`default_nettype wire

/* hw/alu_op_if.sv */
// Decoded control for one operation, valid one cycle after issue and driven only by the decoder.
`timescale 1ns/1ps
`default_nettype none

interface alu_op_if;
  logic       valid;
  logic       is_shift;
  logic       is_sub;
  logic [1:0] logic_fn;      // encoded as the LFN values of the package.
  logic       half;
  logic       shift_arith;
  logic       shift_dir;     // high shifts right.
  logic       write_result;  // low for cmp and unknown opcodes.

  modport decode (
    output valid, is_shift, is_sub, logic_fn, half, shift_arith, shift_dir, write_result
  );

  modport unit (
    input valid, is_shift, is_sub, logic_fn, half, shift_arith, shift_dir, write_result
  );

endinterface

`default_nettype wire

/* hw/alu_pkg.sv */
// Opcodes are five bits wide and the top bit selects the half-width form of each base code.
`default_nettype none

package alu_pkg;

  // ###################################################################
  // opcode map
  // ###################################################################
  localparam int unsigned OPC_W        = 5;
  localparam int unsigned OPC_HALF_BIT = 4;  // set means the low DATA_W/2 bits only.

  localparam logic [OPC_W-1:0] OPC_ADD = 5'd0;
  localparam logic [OPC_W-1:0] OPC_SUB = 5'd1;
  localparam logic [OPC_W-1:0] OPC_AND = 5'd2;
  localparam logic [OPC_W-1:0] OPC_OR  = 5'd3;
  localparam logic [OPC_W-1:0] OPC_XOR = 5'd4;
  localparam logic [OPC_W-1:0] OPC_CMP = 5'd5;  // subtract that writes only the flags.
  localparam logic [OPC_W-1:0] OPC_SHL = 5'd6;
  localparam logic [OPC_W-1:0] OPC_SHR = 5'd7;
  localparam logic [OPC_W-1:0] OPC_SAR = 5'd8;

  // logic function select carried on the control bundle.
  localparam logic [1:0] LFN_NONE = 2'd0;  // adder path.
  localparam logic [1:0] LFN_AND  = 2'd1;
  localparam logic [1:0] LFN_OR   = 2'd2;
  localparam logic [1:0] LFN_XOR  = 2'd3;

  // ###################################################################
  // flags and width
  // ###################################################################
  localparam int unsigned FLAG_W     = 4;
  localparam int unsigned FLAG_ZERO  = 0;
  localparam int unsigned FLAG_SIGN  = 1;
  localparam int unsigned FLAG_CARRY = 2;  // carry out, or no borrow on subtract.
  localparam int unsigned FLAG_OVF   = 3;

  localparam int unsigned DEFAULT_DATA_W = 64;

endpackage

`default_nettype wire
